// File: logic/cal_pkg.sv
// calculator package with widths, button and switch positions, glyph codes and segment table
package cal_pkg;

    localparam int digit_width    = 4;
    localparam int operand_digits = 3;
    localparam int result_width   = 32;
    // wide enough for 999 * 999
    localparam int mag_width      = 20;
    localparam int result_digits  = 8;

    // button bit positions, lower index wins
    localparam int button_width = 5;
    localparam int button_left  = 0;
    localparam int button_right = 1;
    localparam int button_up    = 2;
    localparam int button_down  = 3;
    localparam int button_mid   = 4;

    // operation switches, lowest set bit selects
    localparam int switch_width = 3;
    localparam int op_add       = 0;
    localparam int op_sub       = 1;
    localparam int op_mul       = 2;

    localparam logic [digit_width-1:0] glyph_blank = 4'ha;
    localparam logic [digit_width-1:0] glyph_minus = 4'hb;

    // active low, segment a in the msb and dp in the lsb
    localparam logic [7:0] seg_patterns [12] = '{
        8'b0000_0011,
        8'b1001_1111,
        8'b0010_0101,
        8'b0000_1101,
        8'b1001_1001,
        8'b0100_1001,
        8'b0100_0001,
        8'b0001_1111,
        8'b0000_0001,
        8'b0001_1001,
        8'b1111_1111,
        8'b1111_1101
    };

    localparam logic [3:0] ctrl_off = 4'b1111;

endpackage

// File: logic/button_qualify.sv
// button qualifier: debounce, lowest-index priority and one-cycle press pulses
`timescale 1ns/100ps
module button_qualify #(
    parameter int debounce_cycles = 1000
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cal_pkg::button_width-1:0] button,
    output logic                             press_left,
    output logic                             press_right,
    output logic                             press_up,
    output logic                             press_down,
    output logic                             press_mid
);
    import cal_pkg::*;

    localparam int cnt_width = $clog2(debounce_cycles + 1);

    logic [cnt_width-1:0]    stable_cnt [button_width];
    logic [button_width-1:0] raw_q;
    logic [button_width-1:0] level;
    logic [button_width-1:0] level_q;
    logic [button_width-1:0] press;
    logic                    lower_held;

    always_ff @(posedge clk) begin
        if (rst) begin
            raw_q   <= '0;
            level   <= '0;
            level_q <= '0;
            for (int i = 0; i < button_width; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            raw_q   <= button;
            level_q <= level;
            for (int i = 0; i < button_width; i++) begin
                // any change restarts the stability window
                if (button[i] != raw_q[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == cnt_width'(debounce_cycles - 1)) begin
                    level[i] <= raw_q[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // rising edge, masked by any lower button held
    always_comb begin
        lower_held = 1'b0;
        for (int i = 0; i < button_width; i++) begin
            press[i]   = level[i] & ~level_q[i] & ~lower_held;
            lower_held = lower_held | level[i];
        end
    end

    assign press_left  = press[button_left];
    assign press_right = press[button_right];
    assign press_up    = press[button_up];
    assign press_down  = press[button_down];
    assign press_mid   = press[button_mid];

    a_single_press: assert property (@(posedge clk) disable iff (rst) $onehot0(press));

endmodule

// File: logic/calc_control.sv
// calculator sequencer, one-hot over entry, execution, conversion and display
`timescale 1ns/100ps
module calc_control (
    input  logic clk,
    input  logic rst,
    input  logic press_mid,
    input  logic result_valid,
    input  logic bcd_done,
    input  logic last_page,
    output logic entry_clear,
    output logic capture_a,
    output logic capture_b,
    output logic editing,
    output logic show_result
);

    localparam int st_idle    = 0;
    localparam int st_input_a = 1;
    localparam int st_input_b = 2;
    localparam int st_exe     = 3;
    localparam int st_convert = 4;
    localparam int st_display = 5;

    logic [5:0] state;
    logic [5:0] state_next;
    logic       idle_to_a;
    logic       a_to_b;
    logic       b_to_exe;
    logic       exe_to_cvt;
    logic       cvt_to_disp;
    logic       disp_to_a;

    assign idle_to_a   = state[st_idle];
    assign a_to_b      = state[st_input_a] & press_mid;
    assign b_to_exe    = state[st_input_b] & press_mid;
    assign exe_to_cvt  = state[st_exe] & result_valid;
    assign cvt_to_disp = state[st_convert] & bcd_done;
    // mid on the final page starts a new calculation
    assign disp_to_a   = state[st_display] & press_mid & last_page;

    always_comb begin
        state_next = state;
        if (idle_to_a || disp_to_a) begin
            state_next = 6'(1 << st_input_a);
        end else if (a_to_b) begin
            state_next = 6'(1 << st_input_b);
        end else if (b_to_exe) begin
            state_next = 6'(1 << st_exe);
        end else if (exe_to_cvt) begin
            state_next = 6'(1 << st_convert);
        end else if (cvt_to_disp) begin
            state_next = 6'(1 << st_display);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= 6'(1 << st_idle);
        end else begin
            state <= state_next;
        end
    end

    assign entry_clear = idle_to_a | a_to_b | disp_to_a;
    assign capture_a   = a_to_b;
    assign capture_b   = b_to_exe;
    assign editing     = state[st_input_a] | state[st_input_b];
    assign show_result = state[st_display];

    a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

endmodule

// File: logic/operand_entry.sv
// operand entry: cursor, digit and sign editing, capture of operands a and b
`timescale 1ns/100ps
module operand_entry (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     entry_clear,
    input  logic                     capture_a,
    input  logic                     capture_b,
    input  logic                     editing,
    input  logic                     press_left,
    input  logic                     press_right,
    input  logic                     press_up,
    input  logic                     press_down,
    output logic [cal_pkg::operand_digits-1:0][cal_pkg::digit_width-1:0] live_digits,
    output logic                     live_neg,
    output logic signed [15:0]       a_value,
    output logic signed [15:0]       b_value
);
    import cal_pkg::*;

    // cursor 0..2 selects a digit, 3 selects the sign
    localparam logic [1:0] cursor_sign = 2'd3;

    logic [1:0]         cursor;
    logic [15:0]        entry_mag;
    logic signed [15:0] entry_value;

    always_ff @(posedge clk) begin
        if (rst || entry_clear) begin
            cursor      <= '0;
            live_digits <= '0;
            live_neg    <= 1'b0;
        end else if (editing) begin
            if (press_left && cursor != cursor_sign) begin
                cursor <= cursor + 1'b1;
            end else if (press_right && cursor != 2'd0) begin
                cursor <= cursor - 1'b1;
            end
            if (cursor == cursor_sign) begin
                if (press_up || press_down) begin
                    live_neg <= ~live_neg;
                end
            end else if (press_up) begin
                live_digits[cursor] <= (live_digits[cursor] == 4'd9) ?
                                       4'd0 : live_digits[cursor] + 4'd1;
            end else if (press_down) begin
                live_digits[cursor] <= (live_digits[cursor] == 4'd0) ?
                                       4'd9 : live_digits[cursor] - 4'd1;
            end
        end
    end

    assign entry_mag = 16'(live_digits[2]) * 16'd100
                     + 16'(live_digits[1]) * 16'd10
                     + 16'(live_digits[0]);
    assign entry_value = live_neg ? -$signed(entry_mag) : $signed(entry_mag);

    always_ff @(posedge clk) begin
        if (capture_a) begin
            a_value <= entry_value;
        end
        if (capture_b) begin
            b_value <= entry_value;
        end
    end

    for (genvar i = 0; i < operand_digits; i++) begin : g_digit_check
        a_digit_decimal: assert property (@(posedge clk) disable iff (rst)
            live_digits[i] <= 4'd9);
    end

endmodule

// File: logic/alu_exec.sv
// integer execution: operation select, signed add, subtract, multiply and result register
`timescale 1ns/100ps
module alu_exec (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             capture_b,
    input  logic [cal_pkg::switch_width-1:0] switches,
    input  logic signed [15:0]               a_value,
    input  logic signed [15:0]               b_value,
    output logic                             result_valid,
    output logic                             result_neg,
    output logic                             invalid_op,
    output logic [cal_pkg::mag_width-1:0]    result_mag
);
    import cal_pkg::*;

    logic [switch_width-1:0]        switch_q;
    logic [switch_width-1:0]        op_qual;
    logic signed [result_width-1:0] a_ext;
    logic signed [result_width-1:0] b_ext;
    logic signed [result_width-1:0] result;
    logic [result_width-1:0]        result_abs;

    // lowest set switch wins
    assign op_qual[op_add] = switch_q[op_add];
    assign op_qual[op_sub] = switch_q[op_sub] & ~switch_q[op_add];
    assign op_qual[op_mul] = switch_q[op_mul] & ~(|switch_q[op_mul-1:0]);

    assign a_ext = a_value;
    assign b_ext = b_value;

    always_comb begin
        result = '0;
        if (op_qual[op_add]) begin
            result = a_ext + b_ext;
        end else if (op_qual[op_sub]) begin
            result = a_ext - b_ext;
        end else if (op_qual[op_mul]) begin
            result = a_ext * b_ext;
        end
    end

    assign result_abs = result[result_width-1] ? -result : result;

    always_ff @(posedge clk) begin
        if (rst) begin
            switch_q     <= '0;
            result_valid <= 1'b0;
            result_neg   <= 1'b0;
            invalid_op   <= 1'b0;
        end else begin
            result_valid <= capture_b;
            if (capture_b) begin
                switch_q <= switches;
            end
            if (result_valid) begin
                result_neg <= result[result_width-1];
                invalid_op <= ~(|op_qual);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            result_mag <= result_abs[mag_width-1:0];
        end
    end

endmodule

// File: logic/result_bcd.sv
// serial binary to bcd conversion of the result magnitude, digits held after done
`timescale 1ns/100ps
module result_bcd (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          result_valid,
    input  logic [cal_pkg::mag_width-1:0] result_mag,
    output logic [cal_pkg::result_digits-1:0][cal_pkg::digit_width-1:0] bcd_digits,
    output logic                          bcd_done
);
    import cal_pkg::*;

    localparam int idx_width = $clog2(mag_width);
    localparam int bcd_bits  = result_digits * digit_width;

    logic                 busy;
    logic [idx_width-1:0] bit_idx;
    logic [bcd_bits-1:0]  adjusted;

    // add 3 to every digit of 5 or more before the shift
    always_comb begin
        adjusted = bcd_digits;
        for (int i = 0; i < result_digits; i++) begin
            if (bcd_digits[i] >= 4'd5) begin
                adjusted[i*digit_width +: digit_width] = bcd_digits[i] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            bit_idx  <= '0;
            bcd_done <= 1'b0;
        end else begin
            bcd_done <= busy && bit_idx == '0;
            if (result_valid) begin
                busy    <= 1'b1;
                bit_idx <= idx_width'(mag_width - 1);
            end else if (busy) begin
                if (bit_idx == '0) begin
                    busy <= 1'b0;
                end else begin
                    bit_idx <= bit_idx - 1'b1;
                end
            end
        end
    end

    // msb first, one magnitude bit per cycle
    always_ff @(posedge clk) begin
        if (result_valid) begin
            bcd_digits <= '0;
        end else if (busy) begin
            bcd_digits <= {adjusted[bcd_bits-2:0], result_mag[bit_idx]};
        end
    end

endmodule

// File: logic/seg_display.sv
// seven-segment scan: digit enables, result pages, glyph select and segment decode
`timescale 1ns/100ps
module seg_display #(
    parameter int scan_cycles = 1024
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       editing,
    input  logic       show_result,
    input  logic       press_mid,
    input  logic [cal_pkg::operand_digits-1:0][cal_pkg::digit_width-1:0] live_digits,
    input  logic       live_neg,
    input  logic       result_neg,
    input  logic       invalid_op,
    input  logic [cal_pkg::result_digits-1:0][cal_pkg::digit_width-1:0] bcd_digits,
    output logic       last_page,
    output logic [3:0] digit_ctrl,
    output logic [7:0] digit_seg,
    output logic [2:0] display_stage
);
    import cal_pkg::*;

    localparam int scan_width = $clog2(scan_cycles + 1);

    logic [scan_width-1:0]  scan_cnt;
    logic [1:0]             scan_pos;
    logic                   page;
    logic                   scan_active;
    logic [digit_width-1:0] glyph;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            scan_pos <= '0;
        end else if (scan_cnt == scan_width'(scan_cycles - 1)) begin
            scan_cnt <= '0;
            scan_pos <= scan_pos + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // an invalid operation has a single, dark page
    assign last_page = invalid_op | page;

    always_ff @(posedge clk) begin
        if (rst || !show_result) begin
            page <= 1'b0;
        end else if (press_mid && !last_page) begin
            page <= 1'b1;
        end
    end

    assign display_stage = 3'(page) + 3'd1;
    assign scan_active   = editing | (show_result & ~invalid_op);
    assign digit_ctrl    = scan_active ? ~(4'b0001 << scan_pos) : ctrl_off;

    always_comb begin
        glyph = glyph_blank;
        if (editing) begin
            if (scan_pos == 2'd3) begin
                glyph = live_neg ? glyph_minus : glyph_blank;
            end else begin
                glyph = live_digits[scan_pos];
            end
        end else if (show_result) begin
            if (!page && scan_pos == 2'd3) begin
                glyph = result_neg ? glyph_minus : glyph_blank;
            end else begin
                // page 0 takes digits 4 to 6, page 1 digits 0 to 3
                glyph = bcd_digits[{~page, scan_pos}];
            end
        end
    end

    assign digit_seg = seg_patterns[glyph];

    a_page_bound: assert property (@(posedge clk) disable iff (rst)
        show_result && invalid_op |-> !page);

endmodule

// File: logic/cal_top.sv
// calculator top level connecting buttons, sequencer, datapath and display
`timescale 1ns/100ps
module cal_top #(
    parameter int debounce_cycles = 1000,
    parameter int scan_cycles     = 1024
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cal_pkg::button_width-1:0] board_cal_button,
    input  logic [cal_pkg::switch_width-1:0] board_cal_switchs,
    output logic [3:0]                       cal_board_digit_ctrl,
    output logic [7:0]                       cal_board_digit_seg,
    output logic                             cal_board_exe_done,
    output logic [2:0]                       cal_board_display_stage
);
    import cal_pkg::*;

    logic press_left;
    logic press_right;
    logic press_up;
    logic press_down;
    logic press_mid;
    logic entry_clear;
    logic capture_a;
    logic capture_b;
    logic editing;
    logic show_result;
    logic result_valid;
    logic result_neg;
    logic invalid_op;
    logic bcd_done;
    logic last_page;
    logic live_neg;

    logic [operand_digits-1:0][digit_width-1:0] live_digits;
    logic signed [15:0]                         a_value;
    logic signed [15:0]                         b_value;
    logic [mag_width-1:0]                       result_mag;
    logic [result_digits-1:0][digit_width-1:0]  bcd_digits;

    button_qualify #(
        .debounce_cycles(debounce_cycles)
    ) u_button_qualify (
        .clk        (clk),
        .rst        (rst),
        .button     (board_cal_button),
        .press_left (press_left),
        .press_right(press_right),
        .press_up   (press_up),
        .press_down (press_down),
        .press_mid  (press_mid)
    );

    calc_control u_calc_control (
        .clk         (clk),
        .rst         (rst),
        .press_mid   (press_mid),
        .result_valid(result_valid),
        .bcd_done    (bcd_done),
        .last_page   (last_page),
        .entry_clear (entry_clear),
        .capture_a   (capture_a),
        .capture_b   (capture_b),
        .editing     (editing),
        .show_result (show_result)
    );

    operand_entry u_operand_entry (
        .clk        (clk),
        .rst        (rst),
        .entry_clear(entry_clear),
        .capture_a  (capture_a),
        .capture_b  (capture_b),
        .editing    (editing),
        .press_left (press_left),
        .press_right(press_right),
        .press_up   (press_up),
        .press_down (press_down),
        .live_digits(live_digits),
        .live_neg   (live_neg),
        .a_value    (a_value),
        .b_value    (b_value)
    );

    alu_exec u_alu_exec (
        .clk         (clk),
        .rst         (rst),
        .capture_b   (capture_b),
        .switches    (board_cal_switchs),
        .a_value     (a_value),
        .b_value     (b_value),
        .result_valid(result_valid),
        .result_neg  (result_neg),
        .invalid_op  (invalid_op),
        .result_mag  (result_mag)
    );

    result_bcd u_result_bcd (
        .clk         (clk),
        .rst         (rst),
        .result_valid(result_valid),
        .result_mag  (result_mag),
        .bcd_digits  (bcd_digits),
        .bcd_done    (bcd_done)
    );

    seg_display #(
        .scan_cycles(scan_cycles)
    ) u_seg_display (
        .clk          (clk),
        .rst          (rst),
        .editing      (editing),
        .show_result  (show_result),
        .press_mid    (press_mid),
        .live_digits  (live_digits),
        .live_neg     (live_neg),
        .result_neg   (result_neg),
        .invalid_op   (invalid_op),
        .bcd_digits   (bcd_digits),
        .last_page    (last_page),
        .digit_ctrl   (cal_board_digit_ctrl),
        .digit_seg    (cal_board_digit_seg),
        .display_stage(cal_board_display_stage)
    );

    assign cal_board_exe_done = show_result;

endmodule

// File: test/cal_tb.sv
// calculator testbench: button stimulus, entry and result model, display assertions, watchdog
`timescale 1ns/100ps
module cal_tb;
    import cal_pkg::*;

    localparam int debounce_cycles = 4;
    localparam int scan_cycles     = 2;
    localparam int hold_cycles     = 8;
    localparam int num_ops         = 6;
    localparam int presses_per_op  = 48;
    localparam int watchdog_cycles = num_ops * (presses_per_op * 16 + mag_width + 50);

    localparam logic [button_width-1:0] key_left  = button_width'(1 << button_left);
    localparam logic [button_width-1:0] key_right = button_width'(1 << button_right);
    localparam logic [button_width-1:0] key_up    = button_width'(1 << button_up);
    localparam logic [button_width-1:0] key_down  = button_width'(1 << button_down);
    localparam logic [button_width-1:0] key_mid   = button_width'(1 << button_mid);

    localparam logic [2:0] mode_busy    = 3'd0;
    localparam logic [2:0] mode_entry   = 3'd1;
    localparam logic [2:0] mode_result  = 3'd2;
    localparam logic [2:0] mode_invalid = 3'd3;

    logic                    clk;
    logic                    rst;
    logic [button_width-1:0] button;
    logic [switch_width-1:0] switches;
    logic [3:0]              digit_ctrl;
    logic [7:0]              digit_seg;
    logic                    exe_done;
    logic [2:0]              display_stage;

    // what the display should be showing
    logic [2:0]             mode;
    logic                   settled;
    logic [1:0]             model_cursor;
    logic [digit_width-1:0] model_digits [operand_digits];
    logic                   model_neg;
    logic                   model_page;
    logic [digit_width-1:0] res_digits [result_digits];
    logic                   res_neg;
    int                     errors;
    int                     ops_done;

    logic [1:0]             scan_pos;
    logic                   pos_valid;
    logic [digit_width-1:0] exp_code;
    logic [7:0]             exp_seg;

    cal_top #(
        .debounce_cycles(debounce_cycles),
        .scan_cycles    (scan_cycles)
    ) uut (
        .clk                    (clk),
        .rst                    (rst),
        .board_cal_button       (button),
        .board_cal_switchs      (switches),
        .cal_board_digit_ctrl   (digit_ctrl),
        .cal_board_digit_seg    (digit_seg),
        .cal_board_exe_done     (exe_done),
        .cal_board_display_stage(display_stage)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic log_mismatch(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // position from the enables, glyph from the model
    always_comb begin
        pos_valid = 1'b1;
        case (digit_ctrl)
            4'b1110: scan_pos = 2'd0;
            4'b1101: scan_pos = 2'd1;
            4'b1011: scan_pos = 2'd2;
            4'b0111: scan_pos = 2'd3;
            default: begin
                scan_pos  = 2'd0;
                pos_valid = 1'b0;
            end
        endcase
        exp_code = glyph_blank;
        if (mode == mode_entry) begin
            if (scan_pos == 2'd3) begin
                exp_code = model_neg ? glyph_minus : glyph_blank;
            end else begin
                exp_code = model_digits[scan_pos];
            end
        end else if (mode == mode_result) begin
            if (!model_page && scan_pos == 2'd3) begin
                exp_code = res_neg ? glyph_minus : glyph_blank;
            end else if (!model_page) begin
                exp_code = res_digits[scan_pos + 3'd4];
            end else begin
                exp_code = res_digits[scan_pos];
            end
        end
        exp_seg = seg_patterns[exp_code];
    end

    a_entry_view: assert property (@(posedge clk) disable iff (rst)
        settled && mode == mode_entry |-> pos_valid && digit_seg == exp_seg && !exe_done)
        else log_mismatch("entry display or exe_done differs from the model");

    a_busy_view: assert property (@(posedge clk) disable iff (rst)
        settled && mode == mode_busy |-> digit_ctrl == ctrl_off && !exe_done)
        else log_mismatch("display active or exe_done high before the result");

    a_result_view: assert property (@(posedge clk) disable iff (rst)
        settled && mode == mode_result |-> pos_valid && digit_seg == exp_seg && exe_done
            && display_stage == 3'(model_page) + 3'd1)
        else log_mismatch("result page, digit or sign differs from the model");

    a_invalid_view: assert property (@(posedge clk) disable iff (rst)
        settled && mode == mode_invalid |-> digit_ctrl == ctrl_off && exe_done
            && display_stage == 3'd1)
        else log_mismatch("invalid operation does not show a dark single page");

    // exe_done rises a fixed time after the second capture
    a_exe_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(exe_done) |-> $past(uut.capture_b, mag_width + 3))
        else log_mismatch("exe_done latency after capture is wrong");

    function automatic int rand_operand();
        return int'($urandom_range(1998)) - 999;
    endfunction

    task automatic clear_entry();
        model_cursor = 2'd0;
        model_neg    = 1'b0;
        for (int i = 0; i < operand_digits; i++) begin
            model_digits[i] = '0;
        end
    endtask

    // lowest set button wins
    task automatic apply_edit(input logic [button_width-1:0] mask);
        if (mask[button_left]) begin
            if (model_cursor != 2'd3) begin
                model_cursor = model_cursor + 2'd1;
            end
        end else if (mask[button_right]) begin
            if (model_cursor != 2'd0) begin
                model_cursor = model_cursor - 2'd1;
            end
        end else if (mask[button_up] || mask[button_down]) begin
            if (model_cursor == 2'd3) begin
                model_neg = ~model_neg;
            end else if (mask[button_up]) begin
                model_digits[model_cursor] = 4'((model_digits[model_cursor] + 1) % 10);
            end else begin
                model_digits[model_cursor] = 4'((model_digits[model_cursor] + 9) % 10);
            end
        end
    endtask

    task automatic hold_buttons(input logic [button_width-1:0] mask);
        settled = 1'b0;
        button  = mask;
        repeat (hold_cycles) begin
            @(posedge clk);
        end
        #2;
        button = '0;
    endtask

    task automatic settle();
        settled = 1'b1;
        repeat (hold_cycles) begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic edit_press(input logic [button_width-1:0] mask);
        hold_buttons(mask);
        apply_edit(mask);
        settle();
    endtask

    // walks the cursor from wherever it is, shortest way round per digit
    task automatic enter_operand(input int value);
        int mag;
        int target;
        int diff;
        mag = (value < 0) ? -value : value;
        while (model_cursor != 2'd0) begin
            edit_press(key_right);
        end
        for (int i = 0; i < operand_digits; i++) begin
            target = mag % 10;
            mag    = mag / 10;
            diff   = (target - int'(model_digits[i]) + 10) % 10;
            if (diff <= 5) begin
                repeat (diff) edit_press(key_up);
            end else begin
                repeat (10 - diff) edit_press(key_down);
            end
            edit_press(key_left);
        end
        if (model_neg != (value < 0)) begin
            edit_press(key_up);
        end
    endtask

    task automatic predict_result(input int a, input int b, input logic [switch_width-1:0] sw,
                                  output logic invalid);
        int res;
        int mag;
        invalid = 1'b0;
        res     = 0;
        if (sw[op_add]) begin
            res = a + b;
        end else if (sw[op_sub]) begin
            res = a - b;
        end else if (sw[op_mul]) begin
            res = a * b;
        end else begin
            invalid = 1'b1;
        end
        res_neg = (res < 0);
        mag     = res_neg ? -res : res;
        for (int i = 0; i < result_digits; i++) begin
            res_digits[i] = 4'(mag % 10);
            mag           = mag / 10;
        end
    endtask

    task automatic run_operation(input logic [switch_width-1:0] sw, input int a, input int b);
        logic invalid;
        switches = sw;
        enter_operand(a);
        hold_buttons(key_mid);
        clear_entry();
        settle();
        enter_operand(b);
        hold_buttons(key_mid);
        predict_result(a, b, sw, invalid);
        mode = mode_busy;
        settle();
        while (!exe_done) begin
            @(posedge clk);
            #2;
        end
        model_page = 1'b0;
        mode       = invalid ? mode_invalid : mode_result;
        settle();
        if (!invalid) begin
            hold_buttons(key_mid);
            model_page = 1'b1;
            settle();
        end
        // mid on the last page starts over
        hold_buttons(key_mid);
        model_page = 1'b0;
        mode       = mode_entry;
        clear_entry();
        settle();
        ops_done++;
    endtask

    initial begin
        int op_a;
        int op_b;
        void'($urandom(32'he544_d760));
        errors     = 0;
        ops_done   = 0;
        rst        = 1'b1;
        button     = '0;
        switches   = '0;
        mode       = mode_busy;
        settled    = 1'b1;
        model_page = 1'b0;
        res_neg    = 1'b0;
        clear_entry();
        for (int i = 0; i < result_digits; i++) begin
            res_digits[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        mode = mode_entry;
        settle();

        // digit wrap, cursor ends, sign toggle
        edit_press(key_down);
        edit_press(key_up);
        edit_press(key_down);
        edit_press(key_right);
        edit_press(key_up);
        repeat (4) edit_press(key_left);
        edit_press(key_up);
        edit_press(key_down);
        edit_press(key_up);
        edit_press(key_right);
        edit_press(key_right);
        edit_press(key_up);
        // left and up together, only left acts
        edit_press(key_left | key_up);
        edit_press(key_up);
        ops_done++;

        op_a = rand_operand();
        op_b = rand_operand();
        run_operation(3'b001, op_a, op_b);
        op_a = rand_operand();
        op_b = rand_operand();
        run_operation(3'b010, op_a, op_b);
        op_a = rand_operand();
        op_b = rand_operand();
        run_operation(3'b100, op_a, op_b);
        op_a = rand_operand();
        op_b = rand_operand();
        run_operation(3'b101, op_a, op_b);
        op_a = rand_operand();
        op_b = rand_operand();
        run_operation(3'b000, op_a, op_b);

        $display("errors: %0d, operations completed: %0d of %0d", errors, ops_done, num_ops);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) begin
            @(posedge clk);
        end
        $display("timeout: the test did not finish within %0d clock cycles", watchdog_cycles);
        $display("errors: %0d, operations completed: %0d of %0d", errors, ops_done, num_ops);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: cal.f
logic/cal_pkg.sv
logic/button_qualify.sv
logic/calc_control.sv
logic/operand_entry.sv
logic/alu_exec.sv
logic/result_bcd.sv
logic/seg_display.sv
logic/cal_top.sv
test/cal_tb.sv

// File: Bender.yml
package:
  name: cal

sources:
  - logic/cal_pkg.sv
  - logic/button_qualify.sv
  - logic/calc_control.sv
  - logic/operand_entry.sv
  - logic/alu_exec.sv
  - logic/result_bcd.sv
  - logic/seg_display.sv
  - logic/cal_top.sv
  - target: test
    files:
      - test/cal_tb.sv
